/* src.f */
+incdir+include
logic/l2_pkg.sv
logic/l2_arbiter.sv
logic/l2_tag_stage.sv
logic/l2_memory_stage.sv
logic/l2_perf_counters.sv
logic/l2_subsystem.sv
testbench/axi_memory_model.sv
testbench/l2_subsystem_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the L2 subsystem testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module l2_subsystem_tb \
	-f src.f -o l2_subsystem_sim

./obj_dir/l2_subsystem_sim | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"

/* testbench/l2_subsystem_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "l2_params.svh"

module l2_subsystem_tb;

	import l2_pkg::*;

	localparam int RANDOM_REQUESTS = 100;	// Per core

	logic clk;
	logic reset;
	logic req0_valid;
	logic req0_write;
	addr_t req0_address;
	word_t req0_data;
	logic req0_ready;
	logic req1_valid;
	logic req1_write;
	addr_t req1_address;
	word_t req1_data;
	logic req1_ready;
	logic rsp_valid;
	core_id_t rsp_core;
	word_t rsp_data;
	counter_sel_t counter_sel;
	counter_t counter_value;
	addr_t axi_awaddr;
	logic [`L2_AXI_LEN_BITS-1:0] axi_awlen;
	logic axi_awvalid;
	logic axi_awready;
	word_t axi_wdata;
	logic axi_wlast;
	logic axi_wvalid;
	logic axi_wready;
	logic axi_bvalid;
	logic axi_bready;
	addr_t axi_araddr;
	logic [`L2_AXI_LEN_BITS-1:0] axi_arlen;
	logic axi_arvalid;
	logic axi_arready;
	logic axi_rready;
	logic axi_rvalid;
	word_t axi_rdata;

	// Scoreboard
	word_t expect_q0 [$];	// Core 0, issue order
	word_t expect_q1 [$];
	addr_t store_addr_q [$];	// Stores still to appear on AXI
	word_t store_data_q [$];
	word_t shadow_mem [addr_t];
	logic shadow_valid [`L2_NUM_SETS];
	tag_t shadow_tag [`L2_NUM_SETS];
	logic stall_cycle [int];	// Cycles where some core waited for ready
	int exp_hits;
	int exp_misses;
	int exp_stores;
	int axi_reads;
	int axi_writes;
	int reads_before;
	int writes_before;
	int issued;
	int failures;
	int tests_run;
	int tests_failed;
	int test_start_failures;
	int cycle_count;
	string test_name;
	logic [31:0] rand_state;
	core_id_t last_grant;
	logic have_grant;

	l2_subsystem dut_i(.*);
	axi_memory_model mem_i(.*);

	always #4 clk = ~clk;

	function automatic logic [31:0] xorshift_next(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_random();
		rand_state = xorshift_next(rand_state);
		return rand_state;
	endfunction

	// Expected memory word, last store or the fill pattern
	function automatic word_t memory_value(input addr_t address);
		if (shadow_mem.exists(address))
			return shadow_mem[address];
		return address ^ 32'hA5A5A5A5;
	endfunction

	task automatic report_mismatch(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("** Error %s: %s expected %h, actual %h", test_name, what, expected, actual);
		failures++;
	endtask

	task automatic report_failure(input string what);
		$display("Failure in %s: %s", test_name, what);
		failures++;
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_start_failures = failures;
		tests_run++;
	endtask

	task automatic end_test();
		if (failures == test_start_failures)
			$display("Test %s: passed", test_name);
		else
		begin
			$display("Test %s: failed with %0d errors", test_name,
				failures - test_start_failures);
			tests_failed++;
		end
	endtask

	// Shadow memory and shadow tags, updated in acceptance order
	task automatic record_accept(input core_id_t core, input logic write, input addr_t address,
		input word_t data);
		set_t index;
		tag_t tag;
		word_t expected;
		index = address[`L2_SET_BITS+1:2];
		tag = address[31:32-`L2_TAG_BITS];
		if (write)
		begin
			expected = '0;	// Store acknowledge
			shadow_mem[address] = data;
			store_addr_q.push_back(address);
			store_data_q.push_back(data);
			exp_stores++;
		end
		else
		begin
			expected = memory_value(address);
			if (shadow_valid[index] && shadow_tag[index] == tag)
				exp_hits++;
			else
			begin
				exp_misses++;	// Read miss allocates
				shadow_valid[index] = 1'b1;
				shadow_tag[index] = tag;
			end
		end
		if (core)
			expect_q1.push_back(expected);
		else
			expect_q0.push_back(expected);
	endtask

	task automatic drive_request(input core_id_t core, input logic valid, input logic write,
		input addr_t address, input word_t data);
		if (core)
		begin
			req1_valid = valid;
			req1_write = write;
			req1_address = address;
			req1_data = data;
		end
		else
		begin
			req0_valid = valid;
			req0_write = write;
			req0_address = address;
			req0_data = data;
		end
	endtask

	// Entered and left 1 ns after a rising edge, valid still high on return
	task automatic send_request(input core_id_t core, input logic write, input addr_t address,
		input word_t data);
		logic accepted;
		accepted = 1'b0;
		issued++;
		drive_request(core, 1'b1, write, address, data);
		while (!accepted)
		begin
			@(negedge clk);
			accepted = core ? req1_ready : req0_ready;
			if (accepted)
				record_accept(core, write, address, data);
			else
				stall_cycle[cycle_count] = 1'b1;	// Held off this cycle
			@(posedge clk);
			#1;
		end
	endtask

	task automatic read_each(input core_id_t core, input addr_t base, input int count);
		for (int i = 0; i < count; i++)
			send_request(core, 1'b0, base + 32'(4 * i), '0);
		drive_request(core, 1'b0, 1'b0, '0, '0);
	endtask

	task automatic random_traffic(input core_id_t core, input int count);
		logic [31:0] r;
		for (int i = 0; i < count; i++)
		begin
			r = next_random();
			// 64 words over 16 sets, so hits and conflicts both occur
			send_request(core, r[0], 32'h0000_3000 + {24'b0, r[7:2], 2'b00}, next_random());
			if (r[9:8] != 0)
			begin
				drive_request(core, 1'b0, 1'b0, '0, '0);
				repeat (r[9:8]) @(posedge clk);
				#1;
			end
		end
		drive_request(core, 1'b0, 1'b0, '0, '0);
	endtask

	// Wait until every response is back
	task automatic drain();
		do
		begin
			@(posedge clk);
			#1;
		end while (expect_q0.size() != 0 || expect_q1.size() != 0);
	endtask

	task automatic check_counter(input counter_sel_t sel, input int expected, input string what);
		counter_sel = sel;
		@(negedge clk);
		assert (counter_value == counter_t'(expected))
		else report_mismatch(what, expected, counter_value);
		@(posedge clk);
		#1;
	endtask

	task automatic check_response();
		word_t expected;
		if (rsp_core == 1'b1 && expect_q1.size() == 0 || rsp_core == 1'b0 && expect_q0.size() == 0)
			report_failure($sformatf("response for core %0d with nothing outstanding", rsp_core));
		else
		begin
			if (rsp_core)
				expected = expect_q1.pop_front();
			else
				expected = expect_q0.pop_front();
			assert (rsp_data == expected)
			else report_mismatch($sformatf("core %0d response", rsp_core), expected, rsp_data);
		end
	endtask

	task automatic check_axi_write();
		if (store_addr_q.size() == 0)
			report_failure("AXI write with no store outstanding");
		else if (axi_awvalid && axi_awready)
		begin
			assert (axi_awaddr == store_addr_q[0])
			else report_mismatch("AXI write address", store_addr_q[0], axi_awaddr);
		end
		else
		begin
			assert (axi_wdata == store_data_q[0])
			else report_mismatch("AXI write data", store_data_q[0], axi_wdata);
			void'(store_addr_q.pop_front());
			void'(store_data_q.pop_front());
			axi_writes++;
		end
	endtask

	// Both cores asking means the last winner loses
	task automatic check_grant();
		core_id_t granted;
		granted = req1_ready;
		if (have_grant && req0_valid && req1_valid)
			assert (granted != last_grant)
			else report_mismatch("granted core", {31'b0, ~last_grant}, {31'b0, granted});
		last_grant = granted;
		have_grant = 1'b1;
	endtask

	// Monitors sample midway between edges
	always @(negedge clk)
	begin
		if (!reset)
		begin
			if (rsp_valid)
				check_response();
			if (axi_arvalid && axi_arready)
				axi_reads++;
			if (axi_awvalid && axi_awready || axi_wvalid && axi_wready)
				check_axi_write();
			if (req0_ready || req1_ready)
				check_grant();
		end
	end

	req0_held: assert property (@(posedge clk) disable iff (reset)
		req0_valid && !req0_ready |=> req0_valid && $stable(req0_write)
			&& $stable(req0_address) && $stable(req0_data))
	else report_failure("core 0 request changed while waiting for ready");

	req1_held: assert property (@(posedge clk) disable iff (reset)
		req1_valid && !req1_ready |=> req1_valid && $stable(req1_write)
			&& $stable(req1_address) && $stable(req1_data))
	else report_failure("core 1 request changed while waiting for ready");

	single_beat: assert property (@(posedge clk) disable iff (reset)
		axi_arlen == 0 && axi_awlen == 0 && axi_wlast)
	else report_failure("AXI transfer is not a single beat");

	// Limit grows with every request issued
	initial
	begin
		cycle_count = 0;
		while (cycle_count <= 400 * issued + 1000)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: run stalled after %0d cycles in %s", cycle_count, test_name);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		drive_request(1'b0, 1'b0, 1'b0, '0, '0);
		drive_request(1'b1, 1'b0, 1'b0, '0, '0);
		counter_sel = '0;
		rand_state = 32'd61;
		have_grant = 1'b0;
		test_name = "startup";
		for (int i = 0; i < `L2_NUM_SETS; i++)
			shadow_valid[i] = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;

		begin_test("reset_state");
		@(negedge clk);
		assert (!req0_ready && !req1_ready && !rsp_valid)
		else report_failure("ready or response high after reset");
		assert (!axi_arvalid && !axi_awvalid && !axi_wvalid && !axi_bready && !axi_rready)
		else report_failure("AXI valid or ready high after reset");
		@(posedge clk);
		#1;
		for (int i = 0; i < `L2_NUM_COUNTERS; i++)
			check_counter(counter_sel_t'(i), 0, "counter after reset");
		end_test();

		begin_test("miss_then_hit");
		reads_before = axi_reads;
		read_each(1'b0, 32'h0000_1000, 4);	// Cold, four sets
		drain();
		assert (axi_reads - reads_before == 4)
		else report_mismatch("AXI reads on first pass", 4, axi_reads - reads_before);
		reads_before = axi_reads;
		read_each(1'b0, 32'h0000_1000, 4);
		drain();
		assert (axi_reads == reads_before)
		else report_mismatch("AXI reads on repeat", 0, axi_reads - reads_before);
		check_counter(2'd0, exp_hits, "read hit counter");
		check_counter(2'd1, exp_misses, "read miss counter");
		end_test();

		begin_test("write_through");
		writes_before = axi_writes;
		for (int i = 0; i < 4; i++)	// Two cached words, two not cached
			send_request(1'b1, 1'b1, (i < 2) ? 32'h1000 + 32'(4 * i) : 32'h1800 + 32'(4 * (i - 2)),
				32'hC0DE_0000 + 32'(i));
		drive_request(1'b1, 1'b0, 1'b0, '0, '0);
		drain();
		assert (axi_writes - writes_before == 4)
		else report_mismatch("AXI writes", 4, axi_writes - writes_before);
		read_each(1'b1, 32'h0000_1000, 2);
		read_each(1'b1, 32'h0000_1800, 2);
		drain();
		check_counter(2'd2, exp_stores, "store counter");
		end_test();

		begin_test("conflict_eviction");
		reads_before = axi_reads;
		for (int i = 0; i < 6; i++)	// Same set, two tags
			send_request(1'b0, 1'b0, (i % 2 == 1) ? 32'h0000_2448 : 32'h0000_2048, '0);
		drive_request(1'b0, 1'b0, 1'b0, '0, '0);
		drain();
		assert (axi_reads - reads_before == 6)
		else report_mismatch("AXI reads", 6, axi_reads - reads_before);
		check_counter(2'd1, exp_misses, "read miss counter");
		end_test();

		begin_test("arbitration");
		fork
			read_each(1'b0, 32'h0000_1000, 8);
			read_each(1'b1, 32'h0000_1100, 8);
		join
		drain();
		end_test();

		begin_test("back_pressure");
		fork
			random_traffic(1'b0, RANDOM_REQUESTS);
			random_traffic(1'b1, RANDOM_REQUESTS);
		join
		drain();
		check_counter(2'd0, exp_hits, "read hit counter");
		check_counter(2'd1, exp_misses, "read miss counter");
		check_counter(2'd2, exp_stores, "store counter");
		check_counter(2'd3, stall_cycle.num(), "stall counter");
		end_test();

		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, failures);
		if (failures == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/axi_memory_model.sv */
`timescale 1ns/10ps
`default_nettype none

module axi_memory_model(
	input wire clk,
	input wire reset,
	input wire l2_pkg::addr_t axi_awaddr,
	input wire axi_awvalid,
	output logic axi_awready,
	input wire l2_pkg::word_t axi_wdata,
	input wire axi_wvalid,
	output logic axi_wready,
	output logic axi_bvalid,
	input wire axi_bready,
	input wire l2_pkg::addr_t axi_araddr,
	input wire axi_arvalid,
	output logic axi_arready,
	input wire axi_rready,
	output logic axi_rvalid,
	output l2_pkg::word_t axi_rdata);

	import l2_pkg::*;

	word_t mem [addr_t];	// Sparse word store
	addr_t write_addr;
	addr_t read_addr;
	logic [31:0] rand_state;
	logic [1:0] delay;	// Idle cycles before the next ready or valid

	function automatic logic [31:0] xorshift_next(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Untouched words hold a pattern of their own address
	function automatic word_t read_word(input addr_t address);
		if (mem.exists(address))
			return mem[address];
		return address ^ 32'hA5A5A5A5;
	endfunction

	always @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			axi_awready <= 1'b0;
			axi_wready <= 1'b0;
			axi_bvalid <= 1'b0;
			axi_arready <= 1'b0;
			axi_rvalid <= 1'b0;
			axi_rdata <= '0;
			delay <= '0;
			rand_state <= 32'd61;
		end
		else
		begin
			axi_awready <= 1'b0;	// Readies are one-cycle pulses
			axi_wready <= 1'b0;
			axi_arready <= 1'b0;
			if (axi_bvalid && axi_bready)
				axi_bvalid <= 1'b0;
			if (axi_rvalid && axi_rready)
				axi_rvalid <= 1'b0;
			if (axi_awvalid && axi_awready)
				write_addr <= axi_awaddr;
			if (axi_arvalid && axi_arready)
				read_addr <= axi_araddr;
			if (axi_wvalid && axi_wready)
				mem[write_addr] = axi_wdata;

			// One channel served at a time, the master is serial anyway
			if (delay != 0)
				delay <= delay - 2'd1;
			else if (axi_awvalid && !axi_awready)
				axi_awready <= 1'b1;
			else if (axi_wvalid && !axi_wready)
				axi_wready <= 1'b1;
			else if (axi_bready && !axi_bvalid)
				axi_bvalid <= 1'b1;
			else if (axi_arvalid && !axi_arready)
				axi_arready <= 1'b1;
			else if (axi_rready && !axi_rvalid)
			begin
				axi_rvalid <= 1'b1;
				axi_rdata <= read_word(read_addr);
			end

			if (delay == 0)
			begin
				rand_state <= xorshift_next(rand_state);
				delay <= rand_state[1:0];	// 0 to 3 cycles
			end
		end
	end

endmodule

`default_nettype wire

/* logic/l2_subsystem.sv */
`timescale 1ns/10ps
`default_nettype none

`include "l2_params.svh"

module l2_subsystem(
	input wire clk,
	input wire reset,
	input wire req0_valid,
	input wire req0_write,
	input wire l2_pkg::addr_t req0_address,
	input wire l2_pkg::word_t req0_data,
	output logic req0_ready,
	input wire req1_valid,
	input wire req1_write,
	input wire l2_pkg::addr_t req1_address,
	input wire l2_pkg::word_t req1_data,
	output logic req1_ready,
	output logic rsp_valid,
	output l2_pkg::core_id_t rsp_core,
	output l2_pkg::word_t rsp_data,
	input wire l2_pkg::counter_sel_t counter_sel,
	output l2_pkg::counter_t counter_value,
	output l2_pkg::addr_t axi_awaddr,
	output logic [`L2_AXI_LEN_BITS-1:0] axi_awlen,
	output logic axi_awvalid,
	input wire axi_awready,
	output l2_pkg::word_t axi_wdata,
	output logic axi_wlast,
	output logic axi_wvalid,
	input wire axi_wready,
	input wire axi_bvalid,
	output logic axi_bready,
	output l2_pkg::addr_t axi_araddr,
	output logic [`L2_AXI_LEN_BITS-1:0] axi_arlen,
	output logic axi_arvalid,
	input wire axi_arready,
	output logic axi_rready,
	input wire axi_rvalid,
	input wire l2_pkg::word_t axi_rdata);

	import l2_pkg::*;

	// Arbiter to tag stage
	logic arb_valid;
	logic arb_write;
	addr_t arb_address;
	word_t arb_data;
	core_id_t arb_core;
	logic tag_ready;

	// Tag stage to memory stage
	logic lk_valid;
	logic lk_write;
	addr_t lk_address;
	word_t lk_data;
	core_id_t lk_core;
	logic lk_hit;
	logic mem_ready;
	logic fill_valid;
	set_t fill_set;
	tag_t fill_tag;

	// Counter events
	logic ev_read_hit;
	logic ev_read_miss;
	logic ev_store;
	logic ev_stall;

	l2_arbiter arbiter_i(
		.clk(clk),
		.reset(reset),
		.req0_valid(req0_valid),
		.req0_write(req0_write),
		.req0_address(req0_address),
		.req0_data(req0_data),
		.req1_valid(req1_valid),
		.req1_write(req1_write),
		.req1_address(req1_address),
		.req1_data(req1_data),
		.req0_ready(req0_ready),
		.req1_ready(req1_ready),
		.arb_valid(arb_valid),
		.arb_write(arb_write),
		.arb_address(arb_address),
		.arb_data(arb_data),
		.arb_core(arb_core),
		.tag_ready(tag_ready),
		.ev_stall(ev_stall));

	l2_tag_stage tag_stage_i(
		.clk(clk),
		.reset(reset),
		.arb_valid(arb_valid),
		.arb_write(arb_write),
		.arb_address(arb_address),
		.arb_data(arb_data),
		.arb_core(arb_core),
		.tag_ready(tag_ready),
		.lk_valid(lk_valid),
		.lk_write(lk_write),
		.lk_address(lk_address),
		.lk_data(lk_data),
		.lk_core(lk_core),
		.lk_hit(lk_hit),
		.mem_ready(mem_ready),
		.fill_valid(fill_valid),
		.fill_set(fill_set),
		.fill_tag(fill_tag));

	l2_memory_stage memory_stage_i(
		.clk(clk),
		.reset(reset),
		.lk_valid(lk_valid),
		.lk_write(lk_write),
		.lk_address(lk_address),
		.lk_data(lk_data),
		.lk_core(lk_core),
		.lk_hit(lk_hit),
		.mem_ready(mem_ready),
		.fill_valid(fill_valid),
		.fill_set(fill_set),
		.fill_tag(fill_tag),
		.rsp_valid(rsp_valid),
		.rsp_core(rsp_core),
		.rsp_data(rsp_data),
		.ev_read_hit(ev_read_hit),
		.ev_read_miss(ev_read_miss),
		.ev_store(ev_store),
		.axi_awaddr(axi_awaddr),
		.axi_awlen(axi_awlen),
		.axi_awvalid(axi_awvalid),
		.axi_awready(axi_awready),
		.axi_wdata(axi_wdata),
		.axi_wlast(axi_wlast),
		.axi_wvalid(axi_wvalid),
		.axi_wready(axi_wready),
		.axi_bvalid(axi_bvalid),
		.axi_bready(axi_bready),
		.axi_araddr(axi_araddr),
		.axi_arlen(axi_arlen),
		.axi_arvalid(axi_arvalid),
		.axi_arready(axi_arready),
		.axi_rready(axi_rready),
		.axi_rvalid(axi_rvalid),
		.axi_rdata(axi_rdata));

	l2_perf_counters perf_counters_i(
		.clk(clk),
		.reset(reset),
		.ev_read_hit(ev_read_hit),
		.ev_read_miss(ev_read_miss),
		.ev_store(ev_store),
		.ev_stall(ev_stall),
		.counter_sel(counter_sel),
		.counter_value(counter_value));

endmodule

`default_nettype wire

/* logic/l2_perf_counters.sv */
`timescale 1ns/10ps
`default_nettype none

`include "l2_params.svh"

module l2_perf_counters(
	input wire clk,
	input wire reset,
	input wire ev_read_hit,
	input wire ev_read_miss,
	input wire ev_store,
	input wire ev_stall,
	input wire l2_pkg::counter_sel_t counter_sel,
	output l2_pkg::counter_t counter_value);

	import l2_pkg::*;

	counter_t counters [`L2_NUM_COUNTERS];
	logic [`L2_NUM_COUNTERS-1:0] events;

	// Index order matches counter_sel
	assign events = {ev_stall, ev_store, ev_read_miss, ev_read_hit};

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < `L2_NUM_COUNTERS; i++)
				counters[i] <= '0;
		end
		else
		begin
			for (int i = 0; i < `L2_NUM_COUNTERS; i++)
			begin
				if (events[i])
					counters[i] <= counters[i] + 1'b1;	// Wraps silently
			end
		end
	end

	assign counter_value = counters[counter_sel];	// Read without a cycle of delay

endmodule

`default_nettype wire

/* logic/l2_memory_stage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "l2_params.svh"

module l2_memory_stage(
	input wire clk,
	input wire reset,
	input wire lk_valid,
	input wire lk_write,
	input wire l2_pkg::addr_t lk_address,
	input wire l2_pkg::word_t lk_data,
	input wire l2_pkg::core_id_t lk_core,
	input wire lk_hit,
	output logic mem_ready,
	output logic fill_valid,
	output l2_pkg::set_t fill_set,
	output l2_pkg::tag_t fill_tag,
	output logic rsp_valid,
	output l2_pkg::core_id_t rsp_core,
	output l2_pkg::word_t rsp_data,
	output logic ev_read_hit,
	output logic ev_read_miss,
	output logic ev_store,
	output l2_pkg::addr_t axi_awaddr,
	output logic [`L2_AXI_LEN_BITS-1:0] axi_awlen,
	output logic axi_awvalid,
	input wire axi_awready,
	output l2_pkg::word_t axi_wdata,
	output logic axi_wlast,
	output logic axi_wvalid,
	input wire axi_wready,
	input wire axi_bvalid,
	output logic axi_bready,
	output l2_pkg::addr_t axi_araddr,
	output logic [`L2_AXI_LEN_BITS-1:0] axi_arlen,
	output logic axi_arvalid,
	input wire axi_arready,
	output logic axi_rready,
	input wire axi_rvalid,
	input wire l2_pkg::word_t axi_rdata);

	import l2_pkg::*;

	mem_state_t state;
	word_t data_array [`L2_NUM_SETS];
	addr_t req_address;	// Request being serviced over AXI
	word_t req_data;
	core_id_t req_core;
	set_t lk_set;
	logic take;

	// One idle cycle after each response keeps rsp_valid a single pulse
	assign mem_ready = (state == ms_idle) && !rsp_valid;
	assign take = lk_valid && mem_ready;
	assign lk_set = lk_address[`L2_SET_BITS+1:2];

	assign ev_read_hit = take && !lk_write && lk_hit;
	assign ev_read_miss = take && !lk_write && !lk_hit;
	assign ev_store = take && lk_write;

	// Line fill as the read beat lands
	assign fill_valid = (state == ms_read_data) && axi_rvalid;
	assign fill_set = req_address[`L2_SET_BITS+1:2];
	assign fill_tag = req_address[31:32-`L2_TAG_BITS];

	// Single beat transfers only
	assign axi_awaddr = req_address;
	assign axi_awlen = '0;
	assign axi_awvalid = state == ms_write_addr;
	assign axi_wdata = req_data;
	assign axi_wlast = 1'b1;
	assign axi_wvalid = state == ms_write_data;
	assign axi_bready = state == ms_write_resp;
	assign axi_araddr = req_address;
	assign axi_arlen = '0;
	assign axi_arvalid = state == ms_read_addr;
	assign axi_rready = state == ms_read_data;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state <= ms_idle;
			rsp_valid <= 1'b0;
		end
		else
		begin
			rsp_valid <= 1'b0;
			case (state)
				ms_idle:
					if (take)
					begin
						if (lk_write)
							state <= ms_write_addr;	// Write-through, hit or not
						else if (lk_hit)
							rsp_valid <= 1'b1;	// Answer straight from the array
						else
							state <= ms_read_addr;
					end
				ms_read_addr:
					if (axi_arready)
						state <= ms_read_data;
				ms_read_data:
					if (axi_rvalid)
					begin
						state <= ms_idle;
						rsp_valid <= 1'b1;
					end
				ms_write_addr:
					if (axi_awready)
						state <= ms_write_data;
				ms_write_data:
					if (axi_wready)
						state <= ms_write_resp;
				ms_write_resp:
					if (axi_bvalid)
					begin
						state <= ms_idle;
						rsp_valid <= 1'b1;	// Store acknowledge
					end
				default:
					state <= ms_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (take)
		begin
			req_address <= lk_address;
			req_data <= lk_data;
			req_core <= lk_core;
		end

		// Data word update, no allocate on a write miss
		if (take && lk_write && lk_hit)
			data_array[lk_set] <= lk_data;
		else if (fill_valid)
			data_array[fill_set] <= axi_rdata;

		if (take && !lk_write && lk_hit)
		begin
			rsp_core <= lk_core;
			rsp_data <= data_array[lk_set];
		end
		else if (fill_valid)
		begin
			rsp_core <= req_core;
			rsp_data <= axi_rdata;	// Miss data bypasses the array
		end
		else if (axi_bready && axi_bvalid)
		begin
			rsp_core <= req_core;
			rsp_data <= '0;
		end
	end

	// Read and write addresses never overlap
	addr_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(axi_awvalid && axi_arvalid));

	rsp_single_cycle: assert property (@(posedge clk) disable iff (reset)
		rsp_valid |=> !rsp_valid);

endmodule

`default_nettype wire

/* logic/l2_tag_stage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "l2_params.svh"

module l2_tag_stage(
	input wire clk,
	input wire reset,
	input wire arb_valid,
	input wire arb_write,
	input wire l2_pkg::addr_t arb_address,
	input wire l2_pkg::word_t arb_data,
	input wire l2_pkg::core_id_t arb_core,
	output logic tag_ready,
	output logic lk_valid,
	output logic lk_write,
	output l2_pkg::addr_t lk_address,
	output l2_pkg::word_t lk_data,
	output l2_pkg::core_id_t lk_core,
	output logic lk_hit,
	input wire mem_ready,
	input wire fill_valid,
	input wire l2_pkg::set_t fill_set,
	input wire l2_pkg::tag_t fill_tag);

	import l2_pkg::*;

	tag_t tag_array [`L2_NUM_SETS];
	logic [`L2_NUM_SETS-1:0] valid_bits;
	set_t lk_set;
	tag_t lk_tag;

	// Empty, or the held request leaves this edge
	assign tag_ready = !lk_valid || mem_ready;

	assign lk_set = lk_address[`L2_SET_BITS+1:2];	// Above the byte offset
	assign lk_tag = lk_address[31:32-`L2_TAG_BITS];

	// Looked up every cycle, so a fill shows up right away
	assign lk_hit = valid_bits[lk_set] && (tag_array[lk_set] == lk_tag);

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			lk_valid <= 1'b0;
			valid_bits <= '0;	// Cache starts empty
		end
		else
		begin
			if (tag_ready)
				lk_valid <= arb_valid;

			if (fill_valid)
				valid_bits[fill_set] <= 1'b1;
		end
	end

	// Request payload and tags
	always_ff @(posedge clk)
	begin
		if (tag_ready && arb_valid)
		begin
			lk_write <= arb_write;
			lk_address <= arb_address;
			lk_data <= arb_data;
			lk_core <= arb_core;
		end

		if (fill_valid)
			tag_array[fill_set] <= fill_tag;
	end

	// Fills only come from a busy memory stage
	fill_while_busy: assert property (@(posedge clk) disable iff (reset)
		fill_valid |-> !mem_ready);

endmodule

`default_nettype wire

/* logic/l2_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module l2_arbiter(
	input wire clk,
	input wire reset,
	input wire req0_valid,
	input wire req0_write,
	input wire l2_pkg::addr_t req0_address,
	input wire l2_pkg::word_t req0_data,
	input wire req1_valid,
	input wire req1_write,
	input wire l2_pkg::addr_t req1_address,
	input wire l2_pkg::word_t req1_data,
	output logic req0_ready,
	output logic req1_ready,
	output logic arb_valid,
	output logic arb_write,
	output l2_pkg::addr_t arb_address,
	output l2_pkg::word_t arb_data,
	output l2_pkg::core_id_t arb_core,
	input wire tag_ready,
	output logic ev_stall);

	import l2_pkg::*;

	core_id_t select_core;	// Favoured core this cycle
	core_id_t grant_core;
	logic favoured_valid;

	// Favoured core wins if it asks, else the other one
	assign favoured_valid = select_core ? req1_valid : req0_valid;
	assign grant_core = favoured_valid ? select_core : ~select_core;

	assign arb_valid = req0_valid || req1_valid;
	assign arb_write = grant_core ? req1_write : req0_write;
	assign arb_address = grant_core ? req1_address : req0_address;
	assign arb_data = grant_core ? req1_data : req0_data;
	assign arb_core = grant_core;

	// Ready only toward the granted, requesting core
	assign req0_ready = tag_ready && req0_valid && !grant_core;
	assign req1_ready = tag_ready && req1_valid && grant_core;

	assign ev_stall = (req0_valid && !req0_ready) || (req1_valid && !req1_ready);

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			select_core <= 1'b0;
		else if (arb_valid && tag_ready)
			select_core <= ~grant_core;	// Loser gets priority next
	end

	// At most one core accepted per edge
	one_grant: assert property (@(posedge clk) disable iff (reset)
		!(req0_ready && req1_ready));

endmodule

`default_nettype wire

/* logic/l2_pkg.sv */
`default_nettype none

`include "l2_params.svh"

package l2_pkg;

	typedef logic [31:0] addr_t;	// Byte address, word aligned
	typedef logic [31:0] word_t;
	typedef logic [`L2_SET_BITS-1:0] set_t;
	typedef logic [`L2_TAG_BITS-1:0] tag_t;
	typedef logic core_id_t;	// Requesting core
	typedef logic [`L2_COUNTER_BITS-1:0] counter_t;
	typedef logic [$clog2(`L2_NUM_COUNTERS)-1:0] counter_sel_t;

	// Memory stage sequencing
	typedef enum logic [2:0] {
		ms_idle,
		ms_read_addr,
		ms_read_data,
		ms_write_addr,
		ms_write_data,
		ms_write_resp
	} mem_state_t;

endpackage

`default_nettype wire

/* include/l2_params.svh */
`ifndef L2_PARAMS_SVH
`define L2_PARAMS_SVH

// Cache geometry, direct mapped with one 32-bit word per line
`define L2_SET_BITS 4

// Number of lines
`define L2_NUM_SETS (1 << `L2_SET_BITS)

// Tag keeps every address bit above the word offset but the low index bits
`define L2_TAG_BITS (32 - `L2_SET_BITS)

// Event counters: read hit, read miss, store, stall
`define L2_NUM_COUNTERS 4

// Width of each event count
`define L2_COUNTER_BITS 32

// AXI burst length field, single beat only
`define L2_AXI_LEN_BITS 8

`endif
